/* usb_loop_config.svh */
`ifndef USB_LOOP_CONFIG_SVH
`define USB_LOOP_CONFIG_SVH

// width of one slave-fifo bus word
`define USB_DATA_W 32

// words moved per loopback round
`define USB_BURST_WORDS 4096

// buffer address bits, 2**12 words = one full burst
`define USB_BUF_AW 12

// cycles from first low slrd at the pins to valid data on the pins
// matches the bridge's 2-cycle read pipeline
`define USB_READ_LATENCY 2

`endif

/* fx3_pkg.sv */
`include "usb_loop_config.svh"

package fx3_pkg;

    // one word on the slave-fifo data bus
    typedef logic [`USB_DATA_W-1:0] fx3_word_t;

    // socket address on the a1/a0 pins
    // stream-in is the host-bound socket, stream-out the device-bound one
    typedef enum logic [1:0] {
        FX3_ADDR_STREAM_IN  = 2'b00,
        // parked address while chip select is high
        FX3_ADDR_IDLE       = 2'b10,
        FX3_ADDR_STREAM_OUT = 2'b11
    } fx3_addr_e;

endpackage

/* loop_pkg.sv */
package loop_pkg;

    // loopback sequencer modes
    typedef enum logic [1:0] {
        // waiting for host data
        LOOP_IDLE,
        // reading one burst from the bridge
        LOOP_STREAM_OUT,
        // writing the burst back
        LOOP_STREAM_IN
    } loop_state_e;

    // one bit per board led
    typedef logic [7:0] led_pattern_t;

    // led patterns per mode
    localparam led_pattern_t LED_IDLE       = 8'b0000_0000;
    localparam led_pattern_t LED_STREAM_OUT = 8'b0000_0011;
    localparam led_pattern_t LED_STREAM_IN  = 8'b0000_0111;

endpackage

/* fx3_bus_if.sv */
// control levels and write data for the slave-fifo pins
// sampled every cycle, no handshake
interface fx3_bus_if
    import fx3_pkg::*;
();

    // chip select, active low
    logic      slcs_n;
    // read strobe, active low
    logic      slrd_n;
    // bridge output enable, active low
    logic      sloe_n;
    // write strobe, active low
    logic      slwr_n;
    // socket select
    fx3_addr_e faddr;
    // word to write, qualified by slwr_n
    fx3_word_t wdata;

    // sequencer side
    modport master (
        output slcs_n,
        output slrd_n,
        output sloe_n,
        output slwr_n,
        output faddr,
        output wdata
    );

    // output register side
    modport pins (
        input slcs_n,
        input slrd_n,
        input sloe_n,
        input slwr_n,
        input faddr,
        input wdata
    );

endinterface

/* fx3_input_stage.sv */
`include "usb_loop_config.svh"

module fx3_input_stage
    import fx3_pkg::*;
(
    input  logic      usb_clk,
    input  logic      reset_,
    input  logic      flaga_i,
    input  logic      flagb_i,
    input  logic      flagc_i,
    input  logic      flagd_i,
    input  fx3_word_t fdata_i,
    input  logic      capture_i,
    output logic      flaga_o,
    output logic      flagb_o,
    output logic      flagc_o,
    output logic      flagd_o,
    output logic      push_o,
    output fx3_word_t push_data_o
);

    localparam int LAT = `USB_READ_LATENCY;

    // read strobe as seen at the pins, one cycle behind the sequencer
    logic           capture_q;
    // read strobe walking through the bridge latency
    logic [LAT-1:0] cap_dly;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flaga_o   <= 1'b0;
            flagb_o   <= 1'b0;
            flagc_o   <= 1'b0;
            flagd_o   <= 1'b0;
            capture_q <= 1'b0;
            cap_dly   <= '0;
            push_o    <= 1'b0;
        end else begin
            // flags registered once
            flaga_o   <= flaga_i;
            flagb_o   <= flagb_i;
            flagc_o   <= flagc_i;
            flagd_o   <= flagd_i;
            capture_q <= capture_i;
            cap_dly[0] <= capture_q;
            for (int i = 1; i < LAT; i++) begin
                cap_dly[i] <= cap_dly[i-1];
            end
            // last stage marks valid data on fdata_i, push with the flopped word
            push_o <= cap_dly[LAT-1];
        end
    end

    // data flop, free running
    always_ff @(posedge usb_clk) begin
        push_data_o <= fdata_i;
    end

endmodule

/* word_buffer.sv */
`include "usb_loop_config.svh"

// single-clock fifo, one burst deep
module word_buffer
    import fx3_pkg::*;
(
    input  logic      usb_clk,
    input  logic      reset_,
    input  logic      push_i,
    input  fx3_word_t push_data_i,
    input  logic      pop_i,
    output fx3_word_t pop_data_o,
    output logic      empty_o
);

    localparam int AW    = `USB_BUF_AW;
    localparam int DEPTH = 1 << AW;

    fx3_word_t mem [DEPTH];

    // extra msb so a full burst is not mistaken for empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    // storage write
    always_ff @(posedge usb_clk) begin
        if (push_i) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
    end

    // pointers
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // caller never pops when empty
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // head word, valid in the cycle of the pop
    assign pop_data_o = mem[rd_ptr[AW-1:0]];

    assign empty_o = (wr_ptr == rd_ptr);

endmodule

/* transfer_sequencer.sv */
`include "usb_loop_config.svh"

module transfer_sequencer
    import fx3_pkg::*;
    import loop_pkg::*;
(
    input  logic             usb_clk,
    input  logic             reset_,
    input  logic             flaga_i,
    input  logic             flagb_i,
    input  logic             flagc_i,
    input  logic             flagd_i,
    input  logic             push_i,
    input  fx3_word_t        pop_data_i,
    input  logic             empty_i,
    output logic             pop_o,
    fx3_bus_if.master        bus,
    output led_pattern_t     status_led_o
);

    // counters must reach the full burst value
    localparam int CNT_W = `USB_BUF_AW + 1;
    localparam logic [CNT_W-1:0] BURST = CNT_W'(`USB_BURST_WORDS);

    loop_state_e      state;
    loop_state_e      state_next;
    // reads issued, words pushed, words popped
    logic [CNT_W-1:0] rd_cnt;
    logic [CNT_W-1:0] rx_cnt;
    logic [CNT_W-1:0] tx_cnt;
    logic             rd_req;
    led_pattern_t     led_next;

    // read while words remain and flag d allows it
    assign rd_req = (state == LOOP_STREAM_OUT) && (rd_cnt < BURST) && flagd_i;

    // pop only with room at the bridge and words left
    assign pop_o = (state == LOOP_STREAM_IN) && (tx_cnt < BURST) && flagb_i && !empty_i;

    always_comb begin
        state_next = state;
        led_next   = LED_IDLE;
        case (state)
            LOOP_IDLE: begin
                // host has data ready
                if (flagc_i && flagd_i) begin
                    state_next = LOOP_STREAM_OUT;
                end
            end
            LOOP_STREAM_OUT: begin
                led_next = LED_STREAM_OUT;
                // whole burst captured and stream-in socket ready
                if ((rx_cnt == BURST) && flaga_i && flagb_i) begin
                    state_next = LOOP_STREAM_IN;
                end
            end
            LOOP_STREAM_IN: begin
                led_next = LED_STREAM_IN;
                if (tx_cnt == BURST) begin
                    state_next = LOOP_IDLE;
                end
            end
            default: begin
                state_next = LOOP_IDLE;
            end
        endcase
    end

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            state        <= LOOP_IDLE;
            rd_cnt       <= '0;
            rx_cnt       <= '0;
            tx_cnt       <= '0;
            status_led_o <= LED_IDLE;
        end else begin
            state <= state_next;
            // leds flopped so they line up with the pin registers
            status_led_o <= led_next;
            if (state == LOOP_IDLE) begin
                // fresh counts for the next round
                rd_cnt <= '0;
                rx_cnt <= '0;
                tx_cnt <= '0;
            end else begin
                if (rd_req) begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
                if (push_i) begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
                if (pop_o) begin
                    tx_cnt <= tx_cnt + 1'b1;
                end
            end
        end
    end

    // bus levels, registered again in the output stage
    always_comb begin
        bus.slcs_n = (state == LOOP_IDLE);
        bus.sloe_n = (state != LOOP_STREAM_OUT);
        bus.slrd_n = !rd_req;
        bus.slwr_n = !pop_o;
        bus.wdata  = pop_data_i;
        case (state)
            LOOP_STREAM_OUT: bus.faddr = FX3_ADDR_STREAM_OUT;
            LOOP_STREAM_IN:  bus.faddr = FX3_ADDR_STREAM_IN;
            default:         bus.faddr = FX3_ADDR_IDLE;
        endcase
    end

endmodule

/* fx3_output_stage.sv */
// pin registers for every slave-fifo control and the write data
module fx3_output_stage
    import fx3_pkg::*;
(
    input  logic       usb_clk,
    input  logic       reset_,
    fx3_bus_if.pins    bus,
    output logic       slcs_n_o,
    output logic       slrd_n_o,
    output logic       sloe_n_o,
    output logic       slwr_n_o,
    output logic [1:0] faddr_o,
    output fx3_word_t  fdata_o,
    output logic       fdata_oe_o
);

    // controls come out of reset inactive
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            slcs_n_o <= 1'b1;
            slrd_n_o <= 1'b1;
            sloe_n_o <= 1'b1;
            slwr_n_o <= 1'b1;
            faddr_o  <= FX3_ADDR_IDLE;
        end else begin
            slcs_n_o <= bus.slcs_n;
            slrd_n_o <= bus.slrd_n;
            sloe_n_o <= bus.sloe_n;
            slwr_n_o <= bus.slwr_n;
            faddr_o  <= bus.faddr;
        end
    end

    // write data, only meaningful while driving
    always_ff @(posedge usb_clk) begin
        fdata_o <= bus.wdata;
    end

    // drive the bus only in write cycles
    assign fdata_oe_o = ~slwr_n_o;

endmodule

/* usb_loop_top.sv */
`include "usb_loop_config.svh"

module usb_loop_top (
    input  logic                   usb_clk,
    input  logic                   reset_,
    input  logic                   flaga_i,
    input  logic                   flagb_i,
    input  logic                   flagc_i,
    input  logic                   flagd_i,
    input  logic [`USB_DATA_W-1:0] fdata_i,
    output logic [`USB_DATA_W-1:0] fdata_o,
    output logic                   fdata_oe_o,
    output logic                   slcs_n_o,
    output logic                   slrd_n_o,
    output logic                   sloe_n_o,
    output logic                   slwr_n_o,
    output logic                   pktend_n_o,
    output logic [1:0]             faddr_o,
    output logic [7:0]             status_led_o
);

    // registered flags
    logic flaga_q;
    logic flagb_q;
    logic flagc_q;
    logic flagd_q;
    // capture path into the buffer
    logic                   push;
    logic [`USB_DATA_W-1:0] push_data;
    // drain path out of the buffer
    logic                   pop;
    logic [`USB_DATA_W-1:0] pop_data;
    logic                   empty;

    fx3_bus_if bus ();

    // read strobe taken active high from the bus
    fx3_input_stage u_input (
        .usb_clk(usb_clk), .reset_(reset_),
        .flaga_i(flaga_i), .flagb_i(flagb_i), .flagc_i(flagc_i), .flagd_i(flagd_i),
        .fdata_i(fdata_i), .capture_i(~bus.slrd_n),
        .flaga_o(flaga_q), .flagb_o(flagb_q), .flagc_o(flagc_q), .flagd_o(flagd_q),
        .push_o(push), .push_data_o(push_data)
    );

    word_buffer u_buffer (
        .usb_clk(usb_clk), .reset_(reset_),
        .push_i(push), .push_data_i(push_data),
        .pop_i(pop), .pop_data_o(pop_data), .empty_o(empty)
    );

    transfer_sequencer u_seq (
        .usb_clk(usb_clk), .reset_(reset_),
        .flaga_i(flaga_q), .flagb_i(flagb_q), .flagc_i(flagc_q), .flagd_i(flagd_q),
        .push_i(push), .pop_data_i(pop_data), .empty_i(empty),
        .pop_o(pop), .bus(bus.master), .status_led_o(status_led_o)
    );

    fx3_output_stage u_output (
        .usb_clk(usb_clk), .reset_(reset_), .bus(bus.pins),
        .slcs_n_o(slcs_n_o), .slrd_n_o(slrd_n_o), .sloe_n_o(sloe_n_o),
        .slwr_n_o(slwr_n_o), .faddr_o(faddr_o),
        .fdata_o(fdata_o), .fdata_oe_o(fdata_oe_o)
    );

    // no short packets, pktend never asserted
    assign pktend_n_o = 1'b1;

endmodule

/* usb_loop_tb.sv */
`include "usb_loop_config.svh"

module usb_loop_tb;

    localparam int BURST           = `USB_BURST_WORDS;
    localparam int LAT             = `USB_READ_LATENCY;
    localparam int WATCHDOG_CYCLES = 3 * (2 * BURST + 200);
    // bridge model phases
    localparam int PH_IDLE  = 0;
    localparam int PH_READ  = 1;
    localparam int PH_WRITE = 2;

    logic                   usb_clk;
    logic                   reset_;
    logic                   flaga_i, flagb_i, flagc_i, flagd_i;
    logic [`USB_DATA_W-1:0] fdata_i;
    logic [`USB_DATA_W-1:0] fdata_o;
    logic                   fdata_oe_o, slcs_n_o, slrd_n_o, sloe_n_o, slwr_n_o, pktend_n_o;
    logic [1:0]             faddr_o;
    logic [7:0]             status_led_o;

    integer                 seed;
    // words the host sends for both rounds back to back
    logic [`USB_DATA_W-1:0] words [2*BURST];
    // one entry per cycle set when slrd was low
    bit                     rd_pipe [$];
    int                     err_cnt, err_mark, pass_cnt, fail_cnt;
    int                     round, phase, rd_round, wr_round, rd_total, wr_total, serve_idx;
    int                     b_low, stall_left, wr_resumed, resume_wait;
    int                     gap = 10;
    bit                     stalled;

    usb_loop_top DUT (.*);

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        err_cnt++;
    endtask

    task automatic problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // all controls parked and bus not driven
    task automatic check_inactive();
        assert ({slcs_n_o, slrd_n_o, sloe_n_o, slwr_n_o, pktend_n_o} == 5'b11111)
            else mismatch("{slcs_n,slrd_n,sloe_n,slwr_n,pktend_n}",
                          {slcs_n_o, slrd_n_o, sloe_n_o, slwr_n_o, pktend_n_o}, 5'b11111);
        assert (!fdata_oe_o) else mismatch("fdata_oe_o", fdata_oe_o, 0);
        assert (faddr_o == 2'b10) else mismatch("faddr_o", faddr_o, 2'b10);
        assert (status_led_o == 8'h00) else mismatch("status_led_o", status_led_o, 0);
    endtask

    initial begin
        usb_clk = 1'b0;
        forever #50 usb_clk = ~usb_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("watchdog expired, run not finished after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // bridge model and pin checks on the falling edge
    always @(negedge usb_clk) begin
        b_low = flagb_i ? 0 : b_low + 1;
        assert (pktend_n_o) else mismatch("pktend_n_o", pktend_n_o, 1);
        assert (fdata_oe_o == !slwr_n_o) else mismatch("fdata_oe_o", fdata_oe_o, !slwr_n_o);
        if (slcs_n_o) begin
            assert (faddr_o == 2'b10) else mismatch("faddr_o", faddr_o, 2'b10);
            assert (status_led_o == 8'h00) else mismatch("status_led_o", status_led_o, 8'h00);
        end
        if (!slrd_n_o) begin
            assert (faddr_o == 2'b11) else mismatch("faddr_o", faddr_o, 2'b11);
            assert (!sloe_n_o) else mismatch("sloe_n_o", sloe_n_o, 0);
            assert (status_led_o == 8'h03) else mismatch("status_led_o", status_led_o, 8'h03);
            rd_round++;
            rd_total++;
        end
        if (!slwr_n_o) begin
            assert (faddr_o == 2'b00) else mismatch("faddr_o", faddr_o, 2'b00);
            assert (sloe_n_o) else mismatch("sloe_n_o", sloe_n_o, 1);
            assert (status_led_o == 8'h07) else mismatch("status_led_o", status_led_o, 8'h07);
            assert (b_low <= 2) else problem("write seen more than 2 cycles after flag B dropped");
            if (wr_total < 2 * BURST) begin
                assert (fdata_o === words[wr_total])
                    else mismatch("fdata_o", fdata_o, words[wr_total]);
            end else begin
                problem("more words written than the host sent");
            end
            if (stalled && stall_left == 0) begin
                wr_resumed++;
            end
            wr_round++;
            wr_total++;
        end
        // read data comes LAT cycles after the low slrd cycle
        rd_pipe.push_back(!slrd_n_o);
        if (rd_pipe.pop_front()) begin
            assert (serve_idx < 2 * BURST) else problem("more reads than words the host sent");
            fdata_i = words[serve_idx];
            serve_idx++;
        end else begin
            fdata_i = 32'h5a5a_5a5a;
        end
        case (phase)
            PH_IDLE: begin
                if (gap > 0) begin
                    gap--;
                end else if (round < 2) begin
                    // host data ready
                    {flaga_i, flagb_i, flagc_i, flagd_i} = 4'b0011;
                    phase = PH_READ;
                end
            end
            PH_READ: begin
                if (rd_round == BURST) begin
                    // burst taken so the stream-in socket opens
                    {flaga_i, flagb_i, flagc_i, flagd_i} = 4'b1100;
                    phase = PH_WRITE;
                end
            end
            PH_WRITE: begin
                if (wr_round == BURST) begin
                    assert (rd_round == BURST)
                        else mismatch("slrd_n_o low cycles in round", rd_round, BURST);
                    {flaga_i, flagb_i, flagc_i, flagd_i} = 4'b0000;
                    rd_round = 0;
                    wr_round = 0;
                    gap = 10;
                    phase = PH_IDLE;
                    round++;
                end else if (round == 1 && !stalled && wr_round == BURST / 2) begin
                    // bridge fills up halfway through the second round
                    flagb_i = 1'b0;
                    stalled = 1'b1;
                    stall_left = 20;
                end else if (stall_left > 0) begin
                    stall_left--;
                    flagb_i = (stall_left == 0);
                end else if (stalled && resume_wait < 4) begin
                    // first write due 2 cycles after flag B returns
                    resume_wait++;
                    if (resume_wait == 4) begin
                        assert (wr_resumed > 0)
                            else problem("no write within 4 cycles after flag B returned");
                    end
                end
            end
            default: phase = PH_IDLE;
        endcase
    end

    initial begin
        {flaga_i, flagb_i, flagc_i, flagd_i} = 4'b0000;
        fdata_i = '0;
        reset_ = 1'b0;
        seed = 58;
        for (int i = 0; i < 2 * BURST; i++) begin
            words[i] = $random(seed);
        end
        repeat (LAT) rd_pipe.push_back(1'b0);
        // two cycles in reset then one cycle out of it
        repeat (2) begin
            @(negedge usb_clk);
            check_inactive();
        end
        reset_ = 1'b1;
        @(negedge usb_clk);
        check_inactive();
        @(posedge usb_clk);
        end_test("reset values");
        wait (round == 1);
        @(posedge usb_clk);
        end_test("round 1 loopback");
        wait (round == 2);
        @(posedge usb_clk);
        end_test("round 2 loopback with flag B stall");
        // bus must stay quiet once both rounds are done
        repeat (50) @(posedge usb_clk);
        assert (rd_total == 2 * BURST) else mismatch("slrd_n_o low cycles", rd_total, 2 * BURST);
        assert (wr_total == 2 * BURST) else mismatch("slwr_n_o low cycles", wr_total, 2 * BURST);
        end_test("totals after both rounds");
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* usb_loop.f */
+incdir+.
fx3_pkg.sv
loop_pkg.sv
fx3_bus_if.sv
fx3_input_stage.sv
word_buffer.sv
transfer_sequencer.sv
fx3_output_stage.sv
usb_loop_top.sv
usb_loop_tb.sv
